// File: Makefile
TOP = tb_csr_file

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: csr_commit_stage.sv
`timescale 1ns/100ps
`default_nettype none

module csr_commit_stage (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               wr_en_i,
  input  wire csr_pkg::csr_addr_t wr_addr_i,
  input  wire csr_pkg::csr_data_t wr_data_i,
  input  wire logic               commit_i,
  input  wire logic               flush_i,
  output logic                    commit_wr_en_o,
  output csr_pkg::csr_addr_t      commit_addr_o,
  output csr_pkg::csr_data_t      commit_data_o
);
  import csr_pkg::*;

  logic      pending_valid;
  csr_addr_t staged_addr;
  csr_data_t staged_data;

  // only one CSR instruction is in flight, so a single slot is enough
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      staged_addr <= wr_addr_i;
      staged_data <= wr_data_i;
    end
  end

  // a new write wins over a commit or flush of the old one
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending_valid <= 1'b0;
    end else if (wr_en_i) begin
      pending_valid <= 1'b1;
    end else if (commit_i || flush_i) begin
      pending_valid <= 1'b0;
    end
  end

  // released to the bank on the commit edge itself
  assign commit_wr_en_o = commit_i && pending_valid;
  assign commit_addr_o  = staged_addr;
  assign commit_data_o  = staged_data;

endmodule

`default_nettype wire

// File: csr_file_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module csr_file_asserts (
  input wire logic               clk,
  input wire logic               reset,
  input wire logic               atomic_rd_vio_i,
  input wire logic               irq_pending_i,
  input wire logic               mstatus_mie_i,
  input wire csr_pkg::csr_data_t epc_i,
  input wire csr_pkg::csr_data_t evec_i
);

  // checkpoint comes out of reset empty
  vio_after_reset: assert property (@(posedge clk) $fell(reset) |-> !atomic_rd_vio_i)
    else $error("atomic read violation in the first cycle after reset");

  evec_bit1_clear: assert property (@(posedge clk) disable iff (reset) !evec_i[1])
    else $error("evec_o bit 1 is set");

  epc_bit0_clear: assert property (@(posedge clk) disable iff (reset) !epc_i[0])
    else $error("epc_o bit 0 is set");

  // global enable gates every interrupt
  irq_needs_mie: assert property (@(posedge clk) disable iff (reset)
                                  !mstatus_mie_i |-> !irq_pending_i)
    else $error("irq_pending_o high while mstatus.mie is clear");

endmodule

bind csr_file_top csr_file_asserts u_asserts (
  .clk             (clk),
  .reset           (reset),
  .atomic_rd_vio_i (atomic_rd_vio_o),
  .irq_pending_i   (irq_pending_o),
  .mstatus_mie_i   (u_bank.mstatus_q[csr_pkg::mstatus_mie_bit]),
  .epc_i           (epc_o),
  .evec_i          (evec_o)
);

`default_nettype wire

// File: csr_file_top.sv
`timescale 1ns/100ps
`default_nettype none

module csr_file_top (
  input  wire logic                              clk,
  input  wire logic                              reset,
  input  wire logic                              wr_en_i,
  input  wire csr_pkg::csr_addr_t                wr_addr_i,
  input  wire csr_pkg::csr_data_t                wr_data_i,
  input  wire logic                              commit_i,
  input  wire logic                              flush_i,
  input  wire logic                              rd_en_i,
  input  wire csr_pkg::csr_addr_t                rd_addr_i,
  output csr_pkg::csr_data_t                     rd_data_o,
  input  wire logic [csr_pkg::commit_cnt_w-1:0]  commit_count_i,
  input  wire logic                              exception_i,
  input  wire csr_pkg::csr_data_t                exception_pc_i,
  input  wire logic [csr_pkg::cause_w-1:0]       exception_cause_i,
  input  wire logic                              mret_i,
  input  wire logic                              ext_irq_i,
  input  wire logic                              soft_irq_i,
  input  wire logic                              timer_irq_i,
  output logic                                   atomic_rd_vio_o,
  output logic                                   irq_pending_o,
  output csr_pkg::csr_data_t                     epc_o,
  output csr_pkg::csr_data_t                     evec_o
);
  import csr_pkg::*;

  logic      commit_wr_en;
  csr_addr_t commit_addr;
  csr_data_t commit_data;

  csr_state_if state_bus ();

  // stage 1: hold the write until the instruction retires
  csr_commit_stage u_commit (
    .clk            (clk),
    .reset          (reset),
    .wr_en_i        (wr_en_i),
    .wr_addr_i      (wr_addr_i),
    .wr_data_i      (wr_data_i),
    .commit_i       (commit_i),
    .flush_i        (flush_i),
    .commit_wr_en_o (commit_wr_en),
    .commit_addr_o  (commit_addr),
    .commit_data_o  (commit_data)
  );

  // stage 2: architectural registers
  csr_machine_bank u_bank (
    .clk               (clk),
    .reset             (reset),
    .commit_wr_en_i    (commit_wr_en),
    .commit_addr_i     (commit_addr),
    .commit_data_i     (commit_data),
    .commit_count_i    (commit_count_i),
    .exception_i       (exception_i),
    .exception_pc_i    (exception_pc_i),
    .exception_cause_i (exception_cause_i),
    .mret_i            (mret_i),
    .ext_irq_i         (ext_irq_i),
    .soft_irq_i        (soft_irq_i),
    .timer_irq_i       (timer_irq_i),
    .irq_pending_o     (irq_pending_o),
    .epc_o             (epc_o),
    .evec_o            (evec_o),
    .state             (state_bus.bank)
  );

  // stage 3: read mux and atomicity check
  csr_read_port u_read (
    .clk             (clk),
    .reset           (reset),
    .rd_en_i         (rd_en_i),
    .rd_addr_i       (rd_addr_i),
    .flush_i         (flush_i),
    .commit_i        (commit_i),
    .rd_data_o       (rd_data_o),
    .atomic_rd_vio_o (atomic_rd_vio_o),
    .state           (state_bus.reader)
  );

endmodule

`default_nettype wire

// File: csr_machine_bank.sv
`timescale 1ns/100ps
`default_nettype none

module csr_machine_bank (
  input  wire logic                              clk,
  input  wire logic                              reset,
  input  wire logic                              commit_wr_en_i,
  input  wire csr_pkg::csr_addr_t                commit_addr_i,
  input  wire csr_pkg::csr_data_t                commit_data_i,
  input  wire logic [csr_pkg::commit_cnt_w-1:0]  commit_count_i,
  input  wire logic                              exception_i,
  input  wire csr_pkg::csr_data_t                exception_pc_i,
  input  wire logic [csr_pkg::cause_w-1:0]       exception_cause_i,
  input  wire logic                              mret_i,
  input  wire logic                              ext_irq_i,
  input  wire logic                              soft_irq_i,
  input  wire logic                              timer_irq_i,
  output logic                                   irq_pending_o,
  output csr_pkg::csr_data_t                     epc_o,
  output csr_pkg::csr_data_t                     evec_o,
  csr_state_if.bank                              state
);
  import csr_pkg::*;

  csr_data_t mstatus_q, mstatus_d;
  csr_data_t mepc_q, mepc_d;
  csr_data_t mcause_q, mcause_d;
  csr_data_t mie_q;
  csr_data_t mtvec_q;
  csr_data_t mscratch_q;
  csr_data_t mcycle_q;
  csr_data_t minstret_q;
  csr_data_t mip;

  logic wr_mstatus;
  logic wr_mie;
  logic wr_mtvec;
  logic wr_mscratch;
  logic wr_mepc;
  logic wr_mcause;
  logic wr_mcycle;
  logic wr_minstret;

  // address decode of the committed write, mip is read only
  always_comb begin
    wr_mstatus  = 1'b0;
    wr_mie      = 1'b0;
    wr_mtvec    = 1'b0;
    wr_mscratch = 1'b0;
    wr_mepc     = 1'b0;
    wr_mcause   = 1'b0;
    wr_mcycle   = 1'b0;
    wr_minstret = 1'b0;
    if (commit_wr_en_i) begin
      case (commit_addr_i)
        addr_mstatus:  wr_mstatus  = 1'b1;
        addr_mie:      wr_mie      = 1'b1;
        addr_mtvec:    wr_mtvec    = 1'b1;
        addr_mscratch: wr_mscratch = 1'b1;
        addr_mepc:     wr_mepc     = 1'b1;
        addr_mcause:   wr_mcause   = 1'b1;
        addr_mcycle:   wr_mcycle   = 1'b1;
        addr_minstret: wr_minstret = 1'b1;
        default: ;
      endcase
    end
  end

  // software writes first, trap entry and mret override them
  always_comb begin
    mstatus_d = mstatus_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;
    if (wr_mstatus) begin
      mstatus_d = (commit_data_i & mstatus_wr_mask) | (mstatus_q & ~mstatus_wr_mask);
    end
    if (wr_mepc) begin
      mepc_d = commit_data_i & mepc_wr_mask;
    end
    if (wr_mcause) begin
      mcause_d = commit_data_i;
    end
    if (exception_i) begin
      mepc_d   = exception_pc_i & mepc_wr_mask;
      mcause_d = {{(csr_w-cause_w){1'b0}}, exception_cause_i};
      // stack the enable and mask interrupts in the handler
      mstatus_d                   = mstatus_q;
      mstatus_d[mstatus_mpie_bit] = mstatus_q[mstatus_mie_bit];
      mstatus_d[mstatus_mie_bit]  = 1'b0;
    end else if (mret_i) begin
      mstatus_d                   = mstatus_q;
      mstatus_d[mstatus_mie_bit]  = mstatus_q[mstatus_mpie_bit];
      mstatus_d[mstatus_mpie_bit] = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mstatus_q  <= mstatus_reset;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
      if (wr_mie) begin
        mie_q <= commit_data_i & mie_wr_mask;
      end
      if (wr_mtvec) begin
        mtvec_q <= commit_data_i & mtvec_wr_mask;
      end
      if (wr_mscratch) begin
        mscratch_q <= commit_data_i;
      end
      // counters free run unless software overwrites them
      mcycle_q   <= wr_mcycle ? commit_data_i : mcycle_q + 1'b1;
      minstret_q <= wr_minstret ? commit_data_i
                                : minstret_q + csr_data_t'(commit_count_i);
    end
  end

  // level sensitive lines, no latching
  always_comb begin
    mip              = '0;
    mip[irq_m_soft]  = soft_irq_i;
    mip[irq_m_timer] = timer_irq_i;
    mip[irq_m_ext]   = ext_irq_i;
  end

  assign irq_pending_o = (|(mie_q & mip)) && mstatus_q[mstatus_mie_bit];
  assign epc_o         = mepc_q;
  assign evec_o        = mtvec_q;

  assign state.mstatus  = mstatus_q;
  assign state.mie      = mie_q;
  assign state.mtvec    = mtvec_q;
  assign state.mscratch = mscratch_q;
  assign state.mepc     = mepc_q;
  assign state.mcause   = mcause_q;
  assign state.mcycle   = mcycle_q;
  assign state.minstret = minstret_q;
  assign state.mip      = mip;

endmodule

`default_nettype wire

// File: csr_pkg.sv
`default_nettype none

package csr_pkg;

  // datapath widths
  localparam int csr_w        = 64;
  localparam int csr_addr_w   = 12;
  localparam int cause_w      = 5;
  // up to four instructions retire per cycle
  localparam int commit_cnt_w = 3;

  typedef logic [csr_w-1:0]      csr_data_t;
  typedef logic [csr_addr_w-1:0] csr_addr_t;

  // machine mode CSR addresses
  localparam csr_addr_t addr_mstatus  = 12'h300;
  localparam csr_addr_t addr_mie      = 12'h304;
  localparam csr_addr_t addr_mtvec    = 12'h305;
  localparam csr_addr_t addr_mscratch = 12'h340;
  localparam csr_addr_t addr_mepc     = 12'h341;
  localparam csr_addr_t addr_mcause   = 12'h342;
  localparam csr_addr_t addr_mip      = 12'h344;
  localparam csr_addr_t addr_mcycle   = 12'hB00;
  localparam csr_addr_t addr_minstret = 12'hB02;

  // mstatus fields
  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;
  localparam int mstatus_mpp_lsb  = 11;
  localparam logic [1:0] priv_machine = 2'b11;

  // interrupt lines as they sit in mip and mie
  localparam int irq_m_soft  = 3;
  localparam int irq_m_timer = 7;
  localparam int irq_m_ext   = 11;

  // only the global enable and its stacked copy can be written
  localparam csr_data_t mstatus_wr_mask = (csr_data_t'(1) << mstatus_mie_bit) |
                                          (csr_data_t'(1) << mstatus_mpie_bit);

  localparam csr_data_t mie_wr_mask = (csr_data_t'(1) << irq_m_soft)  |
                                      (csr_data_t'(1) << irq_m_timer) |
                                      (csr_data_t'(1) << irq_m_ext);

  // bit 1 of mtvec is reserved
  localparam csr_data_t mtvec_wr_mask = ~(csr_data_t'(1) << 1);

  // instructions are at least 2-byte aligned
  localparam csr_data_t mepc_wr_mask = ~csr_data_t'(1);

  // mpp is hardwired to machine mode
  localparam csr_data_t mstatus_reset = csr_data_t'(priv_machine) << mstatus_mpp_lsb;

endpackage

`default_nettype wire

// File: csr_read_port.sv
`timescale 1ns/100ps
`default_nettype none

module csr_read_port (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               rd_en_i,
  input  wire csr_pkg::csr_addr_t rd_addr_i,
  input  wire logic               flush_i,
  input  wire logic               commit_i,
  output csr_pkg::csr_data_t      rd_data_o,
  output logic                    atomic_rd_vio_o,
  csr_state_if.reader             state
);
  import csr_pkg::*;

  logic      chk_valid;
  csr_addr_t chk_addr;
  csr_data_t chk_data;
  csr_data_t chk_current;

  // shared by the live read and the checkpoint re-read
  function automatic csr_data_t read_csr(input csr_addr_t addr);
    csr_data_t value;
    case (addr)
      addr_mstatus:  value = state.mstatus;
      addr_mie:      value = state.mie;
      addr_mtvec:    value = state.mtvec;
      addr_mscratch: value = state.mscratch;
      addr_mepc:     value = state.mepc;
      addr_mcause:   value = state.mcause;
      addr_mip:      value = state.mip;
      addr_mcycle:   value = state.mcycle;
      addr_minstret: value = state.minstret;
      // unimplemented addresses read as zero
      default:       value = '0;
    endcase
    return value;
  endfunction

  assign rd_data_o = read_csr(rd_addr_i);

  // remember what the CSR instruction saw
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      chk_addr <= rd_addr_i;
      chk_data <= rd_data_o;
    end
  end

  // a new read recaptures even when the old one retires or is squashed
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      chk_valid <= 1'b0;
    end else if (rd_en_i) begin
      chk_valid <= 1'b1;
    end else if (flush_i || commit_i) begin
      chk_valid <= 1'b0;
    end
  end

  assign chk_current = read_csr(chk_addr);

  // the retire logic replays the CSR instruction when this is set
  assign atomic_rd_vio_o = chk_valid && (chk_current != chk_data);

endmodule

`default_nettype wire

// File: csr_state_if.sv
`timescale 1ns/100ps
`default_nettype none

interface csr_state_if;
  import csr_pkg::*;

  // architectural register values
  csr_data_t mstatus;
  csr_data_t mie;
  csr_data_t mtvec;
  csr_data_t mscratch;
  csr_data_t mepc;
  csr_data_t mcause;
  csr_data_t mcycle;
  csr_data_t minstret;
  // live pending bits from the interrupt lines
  csr_data_t mip;

  modport bank (
    output mstatus, mie, mtvec, mscratch, mepc, mcause, mcycle, minstret, mip
  );

  modport reader (
    input mstatus, mie, mtvec, mscratch, mepc, mcause, mcycle, minstret, mip
  );

endinterface

`default_nettype wire

// File: tb.f
csr_pkg.sv
csr_state_if.sv
csr_commit_stage.sv
csr_machine_bank.sv
csr_read_port.sv
csr_file_top.sv
csr_file_asserts.sv
tb_csr_file.sv

// File: tb_csr_file.sv
`timescale 1ns/100ps
`default_nettype none

module tb_csr_file;
  import csr_pkg::*;

  // the tests need fewer than 100 cycles and this only trips on a hang
  localparam int max_cycles = 2000;

  logic                    clk;
  logic                    reset;
  logic                    wr_en;
  csr_addr_t               wr_addr;
  csr_data_t               wr_data;
  logic                    commit;
  logic                    flush;
  logic                    rd_en;
  csr_addr_t               rd_addr;
  csr_data_t               rd_data;
  logic [commit_cnt_w-1:0] commit_count;
  logic                    exception;
  csr_data_t               exception_pc;
  logic [cause_w-1:0]      exception_cause;
  logic                    mret;
  logic                    ext_irq;
  logic                    soft_irq;
  logic                    timer_irq;
  logic                    atomic_rd_vio;
  logic                    irq_pending;
  csr_data_t               epc;
  csr_data_t               evec;

  // expected CSR contents by address
  csr_data_t   model [csr_addr_t];
  logic [31:0] lfsr_state;
  csr_data_t   exp_data;
  logic        check_en;
  int          cycle_count = 0;
  int          check_count = 0;
  int          error_count = 0;
  int          test_count = 0;
  int          test_errors = 0;

  csr_file_top DUT (
    .clk               (clk),
    .reset             (reset),
    .wr_en_i           (wr_en),
    .wr_addr_i         (wr_addr),
    .wr_data_i         (wr_data),
    .commit_i          (commit),
    .flush_i           (flush),
    .rd_en_i           (rd_en),
    .rd_addr_i         (rd_addr),
    .rd_data_o         (rd_data),
    .commit_count_i    (commit_count),
    .exception_i       (exception),
    .exception_pc_i    (exception_pc),
    .exception_cause_i (exception_cause),
    .mret_i            (mret),
    .ext_irq_i         (ext_irq),
    .soft_irq_i        (soft_irq),
    .timer_irq_i       (timer_irq),
    .atomic_rd_vio_o   (atomic_rd_vio),
    .irq_pending_o     (irq_pending),
    .epc_o             (epc),
    .evec_o            (evec)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic csr_data_t random_bits(input int n);
    csr_data_t value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[csr_w-2:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // CSRs never written still hold their reset value of zero
  function automatic csr_data_t expected_read(input csr_addr_t addr);
    if (model.exists(addr)) begin
      return model[addr];
    end
    return '0;
  endfunction

  task automatic model_write(input csr_addr_t addr, input csr_data_t data);
    csr_data_t old;
    old = expected_read(addr);
    case (addr)
      addr_mstatus: model[addr] = (data & mstatus_wr_mask) | (old & ~mstatus_wr_mask);
      addr_mie:     model[addr] = data & mie_wr_mask;
      addr_mtvec:   model[addr] = data & mtvec_wr_mask;
      addr_mepc:    model[addr] = data & mepc_wr_mask;
      default:      model[addr] = data;
    endcase
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
    check_en = 1'b0;
  endtask

  task automatic expect_read(input csr_addr_t addr);
    rd_addr  = addr;
    exp_data = expected_read(addr);
    check_en = 1'b1;
  endtask

  task automatic sample_read(input csr_addr_t addr, output csr_data_t value);
    rd_addr = addr;
    @(negedge clk);
    value = rd_data;
    next_cycle();
  endtask

  task automatic check_value(input string name, input csr_data_t actual,
                             input csr_data_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic commit_write(input csr_addr_t addr, input csr_data_t data);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    next_cycle();
    wr_en  = 1'b0;
    commit = 1'b1;
    next_cycle();
    commit = 1'b0;
    model_write(addr, data);
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("test %0d %s finished with %0d errors", test_count, name,
             error_count - test_errors);
    test_errors = error_count;
  endtask

  // rd_data_o has settled by the falling edge
  always @(negedge clk) begin
    if (check_en) begin
      check_count++;
      if (rd_data !== exp_data) begin
        error_count++;
        $display("[ERROR] %0t ns rd_data_o expected %h actual %h", $time, exp_data, rd_data);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    csr_data_t          data;
    csr_data_t          first;
    csr_data_t          second;
    csr_data_t          count_sum;
    csr_data_t          pc;
    logic [cause_w-1:0] cause;
    reset           = 1'b1;
    wr_en           = 1'b0;
    wr_addr         = '0;
    wr_data         = '0;
    commit          = 1'b0;
    flush           = 1'b0;
    rd_en           = 1'b0;
    rd_addr         = '0;
    commit_count    = '0;
    exception       = 1'b0;
    exception_pc    = '0;
    exception_cause = '0;
    mret            = 1'b0;
    ext_irq         = 1'b0;
    soft_irq        = 1'b0;
    timer_irq       = 1'b0;
    check_en        = 1'b0;
    exp_data        = '0;
    lfsr_state      = 32'heae5;
    model[addr_mstatus] = mstatus_reset;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    next_cycle();

    // staged write stays hidden until the commit edge
    data    = random_bits(csr_w);
    wr_en   = 1'b1;
    wr_addr = addr_mscratch;
    wr_data = data;
    expect_read(addr_mscratch);
    next_cycle();
    wr_en  = 1'b0;
    commit = 1'b1;
    expect_read(addr_mscratch);
    next_cycle();
    commit = 1'b0;
    model_write(addr_mscratch, data);
    expect_read(addr_mscratch);
    next_cycle();
    end_test("deferred write");

    wr_en   = 1'b1;
    wr_data = random_bits(csr_w);
    next_cycle();
    wr_en = 1'b0;
    flush = 1'b1;
    next_cycle();
    flush  = 1'b0;
    commit = 1'b1;
    next_cycle();
    commit = 1'b0;
    expect_read(addr_mscratch);
    next_cycle();
    end_test("flush");

    commit_write(addr_mtvec, random_bits(csr_w));
    expect_read(addr_mtvec);
    @(negedge clk);
    check_value("evec_o", evec, expected_read(addr_mtvec));
    next_cycle();
    commit_write(addr_mepc, random_bits(csr_w));
    expect_read(addr_mepc);
    next_cycle();
    commit_write(addr_mie, random_bits(csr_w));
    expect_read(addr_mie);
    next_cycle();
    commit_write(addr_mstatus, random_bits(csr_w));
    expect_read(addr_mstatus);
    @(negedge clk);
    check_value("rd_data_o mpp", csr_data_t'(rd_data[mstatus_mpp_lsb +: 2]), 64'd3);
    next_cycle();
    end_test("write masks");

    sample_read(addr_mcycle, first);
    repeat (9) next_cycle();
    sample_read(addr_mcycle, second);
    check_value("mcycle delta", second - first, 64'd10);
    sample_read(addr_minstret, first);
    count_sum = '0;
    repeat (12) begin
      commit_count = commit_cnt_w'(random_bits(3) % 5);
      count_sum    = count_sum + csr_data_t'(commit_count);
      next_cycle();
    end
    commit_count = '0;
    sample_read(addr_minstret, second);
    check_value("minstret delta", second - first, count_sum);
    end_test("counters");

    commit_write(addr_mstatus, csr_data_t'(1) << mstatus_mie_bit);
    commit_write(addr_mie, csr_data_t'(1) << irq_m_timer);
    pc              = random_bits(csr_w) & ~csr_data_t'(1);
    cause           = cause_w'(random_bits(cause_w));
    exception       = 1'b1;
    exception_pc    = pc;
    exception_cause = cause;
    next_cycle();
    exception = 1'b0;
    timer_irq = 1'b1;
    model[addr_mepc]    = pc;
    model[addr_mcause]  = csr_data_t'(cause);
    model[addr_mstatus] = mstatus_reset | (csr_data_t'(1) << mstatus_mpie_bit);
    expect_read(addr_mepc);
    @(negedge clk);
    check_value("epc_o", epc, pc);
    check_value("irq_pending_o", csr_data_t'(irq_pending), 64'd0);
    next_cycle();
    expect_read(addr_mcause);
    next_cycle();
    expect_read(addr_mstatus);
    next_cycle();
    mret = 1'b1;
    next_cycle();
    mret = 1'b0;
    model[addr_mstatus] = mstatus_reset | (csr_data_t'(1) << mstatus_mpie_bit) |
                          (csr_data_t'(1) << mstatus_mie_bit);
    expect_read(addr_mstatus);
    @(negedge clk);
    check_value("irq_pending_o", csr_data_t'(irq_pending), 64'd1);
    next_cycle();
    timer_irq = 1'b0;
    end_test("trap and interrupt");

    // the commit retires the reading instruction and the next read sees the new data
    data    = random_bits(csr_w);
    rd_en   = 1'b1;
    rd_addr = addr_mscratch;
    next_cycle();
    rd_en   = 1'b0;
    wr_en   = 1'b1;
    wr_addr = addr_mscratch;
    wr_data = data;
    @(negedge clk);
    check_value("atomic_rd_vio_o", csr_data_t'(atomic_rd_vio), 64'd0);
    next_cycle();
    wr_en  = 1'b0;
    commit = 1'b1;
    @(negedge clk);
    check_value("atomic_rd_vio_o", csr_data_t'(atomic_rd_vio), 64'd0);
    next_cycle();
    commit = 1'b0;
    rd_en  = 1'b1;
    model_write(addr_mscratch, data);
    expect_read(addr_mscratch);
    @(negedge clk);
    check_value("atomic_rd_vio_o", csr_data_t'(atomic_rd_vio), 64'd0);
    next_cycle();
    rd_en = 1'b0;
    @(negedge clk);
    check_value("atomic_rd_vio_o", csr_data_t'(atomic_rd_vio), 64'd0);
    next_cycle();
    // mcycle moves on right after the read
    rd_en   = 1'b1;
    rd_addr = addr_mcycle;
    next_cycle();
    rd_en = 1'b0;
    @(negedge clk);
    check_value("atomic_rd_vio_o", csr_data_t'(atomic_rd_vio), 64'd1);
    next_cycle();
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    @(negedge clk);
    check_value("atomic_rd_vio_o", csr_data_t'(atomic_rd_vio), 64'd0);
    next_cycle();
    end_test("atomic read");

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
